// ==== include/rv_fe_consts.svh ====
`ifndef RV_FE_CONSTS_SVH
`define RV_FE_CONSTS_SVH

// datapath and address width
`define ARCH_WIDTH 32

// first fetch address, kept nonzero so a zero pc marks an empty stage
`define RESET_VECTOR 32'h0000_0100

// major opcode field, inst[6:0]
`define OPC_BRANCH 7'b110_0011
`define OPC_JAL 7'b110_1111

`endif

// ==== verilog/rv_fe_pkg.sv ====
package rv_fe_pkg;

// next pc source
typedef enum logic [1:0] {
    PC_SEL_PC,
    PC_SEL_INC4,
    PC_SEL_ALU
} pc_sel_t;

// branch outcome from the resolution input
typedef enum logic {
    B_NT,
    B_T
} branch_t;

// opcode class, only what the front end needs to steer fetch
typedef enum logic [1:0] {
    KIND_PLAIN,
    KIND_BRANCH,
    KIND_JUMP
} inst_kind_t;

// front end stall FSM
typedef enum logic [2:0] {
    RST,
    STEADY,
    STALL_FLOW,
    STALL_FE_IC,
    STALL_BE
} stall_state_t;

endpackage

// ==== verilog/rv_fe_pc_gen.sv ====
`timescale 1ns/1ps

`include "rv_fe_consts.svh"

module rv_fe_pc_gen import rv_fe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pc_we,
    input  pc_sel_t                pc_sel,
    input  logic [`ARCH_WIDTH-1:0] target_exe,
    output logic [`ARCH_WIDTH-1:0] pc,
    output logic [`ARCH_WIDTH-1:0] imem_req_addr
);

logic [`ARCH_WIDTH-1:0] pc_nx;

// next pc mux
always_comb begin
    case (pc_sel)
        PC_SEL_INC4: pc_nx = pc + `ARCH_WIDTH'd4;
        PC_SEL_ALU: pc_nx = target_exe;
        default: pc_nx = pc;
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        pc <= `RESET_VECTOR;
    end else if (pc_we) begin
        pc <= pc_nx;
    end
end

// pc only moves once its instruction is decoded, so it is the address in flight
assign imem_req_addr = pc;

// catches a misaligned target coming back from execute
assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

// ==== verilog/rv_fe_decode.sv ====
`timescale 1ns/1ps

`include "rv_fe_consts.svh"

module rv_fe_decode import rv_fe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rsp_fire,
    input  logic [`ARCH_WIDTH-1:0] imem_rsp_data,
    input  logic [`ARCH_WIDTH-1:0] fetch_pc,
    input  logic                   bubble_dec,
    input  logic                   advance,
    output logic                   dec_valid,
    output logic [`ARCH_WIDTH-1:0] pc_dec,
    output logic [`ARCH_WIDTH-1:0] inst_dec,
    output inst_kind_t             kind_dec,
    output logic [`ARCH_WIDTH-1:0] imm_dec
);

logic load_rsp;

assign load_rsp = rsp_fire && !bubble_dec;

// stage valid and pc, pc of zero is an empty slot
always_ff @(posedge clk) begin
    if (rst) begin
        dec_valid <= 1'b0;
        pc_dec <= '0;
    end else if (load_rsp) begin
        dec_valid <= 1'b1;
        pc_dec <= fetch_pc;
    end else if (bubble_dec || advance) begin
        // moved on to execute or squashed, either way leave a bubble
        dec_valid <= 1'b0;
        pc_dec <= '0;
    end
end

always_ff @(posedge clk) begin
    if (load_rsp) begin
        inst_dec <= imem_rsp_data;
    end
end

// a bubble always reads as plain so ctrl never stalls on stale data
always_comb begin
    kind_dec = KIND_PLAIN;
    if (dec_valid) begin
        case (inst_dec[6:0])
            `OPC_BRANCH: kind_dec = KIND_BRANCH;
            `OPC_JAL: kind_dec = KIND_JUMP;
            default: kind_dec = KIND_PLAIN;
        endcase
    end
end

// B-type and J-type immediates, sign extended
always_comb begin
    case (kind_dec)
        KIND_BRANCH: imm_dec = {{20{inst_dec[31]}}, inst_dec[7], inst_dec[30:25],
                                inst_dec[11:8], 1'b0};
        KIND_JUMP: imm_dec = {{12{inst_dec[31]}}, inst_dec[19:12], inst_dec[20],
                              inst_dec[30:21], 1'b0};
        default: imm_dec = '0;
    endcase
end

endmodule

// ==== verilog/rv_fe_exec.sv ====
`timescale 1ns/1ps

`include "rv_fe_consts.svh"

module rv_fe_exec import rv_fe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,
    input  logic                   dec_valid,
    input  logic [`ARCH_WIDTH-1:0] pc_dec,
    input  logic [`ARCH_WIDTH-1:0] inst_dec,
    input  inst_kind_t             kind_dec,
    input  logic [`ARCH_WIDTH-1:0] imm_dec,
    input  branch_t                branch_resolution,
    input  logic                   exe_ready,
    output logic                   exe_valid,
    output logic [`ARCH_WIDTH-1:0] exe_pc,
    output logic [`ARCH_WIDTH-1:0] exe_inst,
    output inst_kind_t             kind_exe,
    output logic [`ARCH_WIDTH-1:0] pc_exe,
    output logic [`ARCH_WIDTH-1:0] target_exe,
    output logic                   flow_changed
);

logic [`ARCH_WIDTH-1:0] imm_exe;

// advance is low only while the backend refuses a valid instruction
always_ff @(posedge clk) begin
    if (rst) begin
        exe_valid <= 1'b0;
        exe_pc <= '0;
        kind_exe <= KIND_PLAIN;
    end else if (advance) begin
        exe_valid <= dec_valid;
        exe_pc <= pc_dec;
        kind_exe <= kind_dec;
    end
end

always_ff @(posedge clk) begin
    if (advance) begin
        exe_inst <= inst_dec;
        imm_exe <= imm_dec;
    end
end

// branch and jal targets are both pc relative
assign target_exe = exe_pc + imm_exe;

// ctrl matches this against the stalled pc, zero when empty
assign pc_exe = exe_valid ? exe_pc : '0;

assign flow_changed = exe_valid &&
    ((kind_exe == KIND_JUMP) ||
     ((kind_exe == KIND_BRANCH) && (branch_resolution == B_T)));

// refused instruction must be presented unchanged on the next cycle
assert property (@(posedge clk) disable iff (rst)
    exe_valid && !exe_ready |=> exe_valid && $stable(exe_pc) && $stable(exe_inst))
    else $error("issue port changed under back-pressure");

endmodule

// ==== verilog/rv_fe_ctrl.sv ====
`timescale 1ns/1ps

`include "rv_fe_consts.svh"

module rv_fe_ctrl import rv_fe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   imem_req_ready,
    input  logic                   imem_rsp_valid,
    input  inst_kind_t             kind_dec,
    input  logic [`ARCH_WIDTH-1:0] pc_dec,
    input  logic [`ARCH_WIDTH-1:0] pc_exe,
    input  logic                   exe_valid,
    input  logic                   exe_ready,
    input  logic                   flow_changed,
    output logic                   imem_req_valid,
    output logic                   imem_rsp_ready,
    output logic                   pc_we,
    output pc_sel_t                pc_sel,
    output logic                   bubble_dec,
    output logic                   advance,
    output stall_state_t           state
);

stall_state_t nx_state;
logic req_pending;
logic req_fire;
logic rsp_fire;
logic rsp_take;
logic flow_dec;
logic flow_res;
logic save_stall_pc;
logic clear_stall_pc;
logic [`ARCH_WIDTH-1:0] stall_pc;

// execute can take a new entry when empty or when it is issuing this cycle
assign advance = !exe_valid || exe_ready;

assign flow_dec = (kind_dec == KIND_BRANCH) || (kind_dec == KIND_JUMP);
// the stalling branch has reached execute
assign flow_res = (pc_exe == stall_pc) && (pc_exe != '0);

assign req_fire = imem_req_valid && imem_req_ready;
assign rsp_fire = imem_rsp_valid && imem_rsp_ready;
// response lands in decode this cycle
assign rsp_take = imem_rsp_valid && req_pending && advance;

always_ff @(posedge clk) begin
    if (rst) begin
        state <= RST;
    end else begin
        state <= nx_state;
    end
end

always_comb begin
    nx_state = state;
    save_stall_pc = 1'b0;
    clear_stall_pc = 1'b0;
    pc_we = 1'b0;
    pc_sel = PC_SEL_PC;
    bubble_dec = 1'b0;
    imem_req_valid = 1'b0;
    imem_rsp_ready = 1'b0;

    case (state)
        RST: begin
            // hold off until imem can take the reset vector
            bubble_dec = 1'b1;
            if (imem_req_ready) begin
                nx_state = STALL_FE_IC;
            end
        end

        STALL_FE_IC: begin
            // request the current pc once and wait for its data
            imem_req_valid = !req_pending;
            imem_rsp_ready = req_pending && advance;
            bubble_dec = !rsp_take;
            if (rsp_take) begin
                nx_state = STEADY;
            end
        end

        STEADY, STALL_BE: begin
            // decode holds a fresh instruction whose kind picks the next pc
            clear_stall_pc = 1'b1;
            if (!advance) begin
                // freeze pc and decode while the backend is busy
                nx_state = STALL_BE;
            end else if (flow_dec) begin
                save_stall_pc = 1'b1;
                nx_state = STALL_FLOW;
            end else begin
                pc_we = 1'b1;
                pc_sel = PC_SEL_INC4;
                nx_state = STALL_FE_IC;
            end
        end

        STALL_FLOW: begin
            bubble_dec = 1'b1;
            if (flow_res) begin
                // pc still points at the branch so not taken is just +4
                pc_we = 1'b1;
                pc_sel = flow_changed ? PC_SEL_ALU : PC_SEL_INC4;
                clear_stall_pc = 1'b1;
                nx_state = STALL_FE_IC;
            end
        end

        default: nx_state = RST;
    endcase
end

// save wins over clear when a new flow change shows up in STEADY
always_ff @(posedge clk) begin
    if (rst) begin
        stall_pc <= '0;
    end else if (save_stall_pc) begin
        stall_pc <= pc_dec;
    end else if (clear_stall_pc) begin
        stall_pc <= '0;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        req_pending <= 1'b0;
    end else if (req_fire) begin
        req_pending <= 1'b1;
    end else if (rsp_fire) begin
        req_pending <= 1'b0;
    end
end

// no new request while imem presents the response to the last one
assert property (@(posedge clk) disable iff (rst) imem_rsp_valid |-> !imem_req_valid)
    else $error("imem request raised with a response pending");

// request stays up until imem takes it
assert property (@(posedge clk) disable iff (rst)
    imem_req_valid && !imem_req_ready |=> imem_req_valid)
    else $error("imem request dropped before acceptance");

endmodule

// ==== verilog/rv_fe_top.sv ====
`timescale 1ns/1ps

`include "rv_fe_consts.svh"

module rv_fe_top import rv_fe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   imem_req_valid,
    input  logic                   imem_req_ready,
    output logic [`ARCH_WIDTH-1:0] imem_req_addr,
    input  logic                   imem_rsp_valid,
    output logic                   imem_rsp_ready,
    input  logic [`ARCH_WIDTH-1:0] imem_rsp_data,
    input  branch_t                branch_resolution,
    output logic                   exe_valid,
    output logic [`ARCH_WIDTH-1:0] exe_pc,
    output logic [`ARCH_WIDTH-1:0] exe_inst,
    input  logic                   exe_ready,
    output stall_state_t           state
);

logic [`ARCH_WIDTH-1:0] pc;
logic pc_we;
pc_sel_t pc_sel;
logic bubble_dec;
logic advance;
logic rsp_fire;
logic dec_valid;
logic [`ARCH_WIDTH-1:0] pc_dec;
logic [`ARCH_WIDTH-1:0] inst_dec;
inst_kind_t kind_dec;
logic [`ARCH_WIDTH-1:0] imm_dec;
logic [`ARCH_WIDTH-1:0] pc_exe;
logic [`ARCH_WIDTH-1:0] target_exe;
logic flow_changed;

assign rsp_fire = imem_rsp_valid && imem_rsp_ready;

rv_fe_pc_gen pc_gen0 (
    .clk           (clk),
    .rst           (rst),
    .pc_we         (pc_we),
    .pc_sel        (pc_sel),
    .target_exe    (target_exe),
    .pc            (pc),
    .imem_req_addr (imem_req_addr)
);

rv_fe_decode decode0 (
    .clk           (clk),
    .rst           (rst),
    .rsp_fire      (rsp_fire),
    .imem_rsp_data (imem_rsp_data),
    .fetch_pc      (pc),
    .bubble_dec    (bubble_dec),
    .advance       (advance),
    .dec_valid     (dec_valid),
    .pc_dec        (pc_dec),
    .inst_dec      (inst_dec),
    .kind_dec      (kind_dec),
    .imm_dec       (imm_dec)
);

// kind_exe stays internal to execute, ctrl only needs flow_changed
rv_fe_exec exec0 (
    .clk               (clk),
    .rst               (rst),
    .advance           (advance),
    .dec_valid         (dec_valid),
    .pc_dec            (pc_dec),
    .inst_dec          (inst_dec),
    .kind_dec          (kind_dec),
    .imm_dec           (imm_dec),
    .branch_resolution (branch_resolution),
    .exe_ready         (exe_ready),
    .exe_valid         (exe_valid),
    .exe_pc            (exe_pc),
    .exe_inst          (exe_inst),
    .kind_exe          (),
    .pc_exe            (pc_exe),
    .target_exe        (target_exe),
    .flow_changed      (flow_changed)
);

rv_fe_ctrl ctrl0 (
    .clk            (clk),
    .rst            (rst),
    .imem_req_ready (imem_req_ready),
    .imem_rsp_valid (imem_rsp_valid),
    .kind_dec       (kind_dec),
    .pc_dec         (pc_dec),
    .pc_exe         (pc_exe),
    .exe_valid      (exe_valid),
    .exe_ready      (exe_ready),
    .flow_changed   (flow_changed),
    .imem_req_valid (imem_req_valid),
    .imem_rsp_ready (imem_rsp_ready),
    .pc_we          (pc_we),
    .pc_sel         (pc_sel),
    .bubble_dec     (bubble_dec),
    .advance        (advance),
    .state          (state)
);

endmodule

// ==== sim/rv_fe_tb.sv ====
`timescale 1ns/1ps

`include "rv_fe_consts.svh"

module rv_fe_tb import rv_fe_pkg::*; ();

localparam int MEM_WORDS = 256;
localparam int N_RESET = 1;
localparam int N_STRAIGHT = 24;
localparam int N_LATENCY = 32;
localparam int N_JAL = 12;
localparam int N_BRANCH = 30;
localparam int N_BACKPRESSURE = 40;
localparam int TOTAL_INSTR = N_RESET + N_STRAIGHT + N_LATENCY + N_JAL + N_BRANCH + N_BACKPRESSURE;
// worst case per instruction covers imem waits, a flow stall and refusals
localparam int MAX_LAT = 24;
localparam int MARGIN = 460;
localparam int TIMEOUT_CYCLES = TOTAL_INSTR * MAX_LAT + MARGIN;

logic clk;
logic rst;
logic imem_req_valid;
logic imem_req_ready = 1'b0;
logic [`ARCH_WIDTH-1:0] imem_req_addr;
logic imem_rsp_valid = 1'b0;
logic imem_rsp_ready;
logic [`ARCH_WIDTH-1:0] imem_rsp_data = '0;
branch_t branch_resolution = B_NT;
logic exe_valid;
logic [`ARCH_WIDTH-1:0] exe_pc;
logic [`ARCH_WIDTH-1:0] exe_inst;
logic exe_ready = 1'b1;
stall_state_t state;

// program image plus the kind and taken target of every word
logic [31:0] mem [0:MEM_WORDS-1];
inst_kind_t kind_tab [0:MEM_WORDS-1];
logic [31:0] tgt_tab [0:MEM_WORDS-1];

logic lat_random;
logic bp_random;
logic [15:0] lfsr_q = 16'd47;
int cycle_count = 0;

// reference model and memory model state
logic [31:0] exp_pc = `RESET_VECTOR;
int issued = 0;
logic held_valid = 1'b0;
logic [31:0] held_pc;
logic [31:0] held_inst;
logic rsp_busy = 1'b0;
logic [31:0] rsp_addr;
int rsp_wait = 0;
int req_wait = 0;
branch_t outcome_q[$];

rv_fe_top dut0 (
    .clk               (clk),
    .rst               (rst),
    .imem_req_valid    (imem_req_valid),
    .imem_req_ready    (imem_req_ready),
    .imem_req_addr     (imem_req_addr),
    .imem_rsp_valid    (imem_rsp_valid),
    .imem_rsp_ready    (imem_rsp_ready),
    .imem_rsp_data     (imem_rsp_data),
    .branch_resolution (branch_resolution),
    .exe_valid         (exe_valid),
    .exe_pc            (exe_pc),
    .exe_inst          (exe_inst),
    .exe_ready         (exe_ready),
    .state             (state)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_pc(input string name, input logic [`ARCH_WIDTH-1:0] got,
                        input logic [`ARCH_WIDTH-1:0] exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_inst(input string name, input logic [`ARCH_WIDTH-1:0] got,
                          input logic [`ARCH_WIDTH-1:0] exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_state(input string name, input stall_state_t got,
                           input stall_state_t exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

// galois lfsr stepped once per bit taken
function automatic logic rand_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    return b;
endfunction

function automatic int rand_count();
    int n;
    n = 0;
    if (rand_bit()) n = n + 1;
    if (rand_bit()) n = n + 2;
    return n;
endfunction

function automatic logic [7:0] word_slot(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - `RESET_VECTOR;
    return off[9:2];
endfunction

function automatic logic in_range(input logic [31:0] addr);
    return (addr >= `RESET_VECTOR) && (addr < `RESET_VECTOR + 32'(MEM_WORDS * 4)) &&
           (addr[1:0] == 2'b00);
endfunction

// plain OP-IMM word in which every address bit shows up
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], 7'h13};
endfunction

function automatic logic [31:0] enc_branch(input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], `OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_jal(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, `OPC_JAL};
endfunction

// only forward flow changes so a run always moves on through memory
task automatic build_program(input int branch_every, input int jump_every);
    logic [31:0] addr;
    logic [7:0] slot;
    int pos;
    addr = `RESET_VECTOR;
    for (pos = 0; pos < MEM_WORDS; pos++) begin
        slot = word_slot(addr);
        mem[slot] = fill_word(addr);
        kind_tab[slot] = KIND_PLAIN;
        tgt_tab[slot] = addr + 32'd4;
        if (pos < MEM_WORDS - 4) begin
            if (branch_every > 0 && pos % branch_every == branch_every - 1) begin
                mem[slot] = enc_branch(13'd8);
                kind_tab[slot] = KIND_BRANCH;
                tgt_tab[slot] = addr + 32'd8;
            end else if (jump_every > 0 && pos % jump_every == jump_every - 1) begin
                mem[slot] = enc_jal(21'd12);
                kind_tab[slot] = KIND_JUMP;
                tgt_tab[slot] = addr + 32'd12;
            end
        end
        addr = addr + 32'd4;
    end
endtask

// one issued instruction against the architectural pc
task automatic follow_issue();
    logic [7:0] slot;
    branch_t res;
    if (!in_range(exp_pc)) begin
        stop_with_failure("reference pc left the programmed memory");
    end
    slot = word_slot(exp_pc);
    check_pc("exe_pc", exe_pc, exp_pc);
    check_inst("exe_inst", exe_inst, mem[slot]);
    case (kind_tab[slot])
        KIND_JUMP: exp_pc = tgt_tab[slot];
        KIND_BRANCH: begin
            if (outcome_q.size() == 0) begin
                stop_with_failure("branch issued before its outcome was drawn");
            end else begin
                res = outcome_q.pop_front();
                exp_pc = (res == B_T) ? tgt_tab[slot] : exp_pc + 32'd4;
            end
        end
        default: exp_pc = exp_pc + 32'd4;
    endcase
    issued = issued + 1;
endtask

task automatic serve_memory();
    branch_t res;
    if (imem_rsp_valid && imem_rsp_ready) begin
        imem_rsp_valid <= 1'b0;
        rsp_busy = 1'b0;
        // outcome is drawn as the branch enters decode and held until the next branch
        if (kind_tab[word_slot(rsp_addr)] == KIND_BRANCH) begin
            res = rand_bit() ? B_T : B_NT;
            outcome_q.push_back(res);
            branch_resolution <= res;
        end
    end
    if (imem_req_valid && imem_req_ready) begin
        if (!in_range(imem_req_addr)) begin
            stop_with_failure("fetch address outside the programmed memory");
        end
        rsp_busy = 1'b1;
        rsp_addr = imem_req_addr;
        rsp_wait = lat_random ? rand_count() : 0;
        if (lat_random) begin
            imem_req_ready <= 1'b0;
            req_wait = rand_count();
        end
    end else if (!imem_req_ready) begin
        if (req_wait == 0) imem_req_ready <= 1'b1;
        else req_wait = req_wait - 1;
    end
    if (rsp_busy && !imem_rsp_valid) begin
        if (rsp_wait == 0) begin
            imem_rsp_valid <= 1'b1;
            imem_rsp_data <= mem[word_slot(rsp_addr)];
        end else begin
            rsp_wait = rsp_wait - 1;
        end
    end
endtask

always @(posedge clk) begin
    if (rst) begin
        imem_req_ready <= 1'b1;
        imem_rsp_valid <= 1'b0;
        exe_ready <= 1'b1;
        rsp_busy = 1'b0;
        req_wait = 0;
        held_valid = 1'b0;
        exp_pc = `RESET_VECTOR;
        issued = 0;
        outcome_q.delete();
    end else begin
        // a refused instruction comes back unchanged
        if (held_valid) begin
            check_flag("exe_valid", exe_valid, 1'b1);
            check_pc("exe_pc", exe_pc, held_pc);
            check_inst("exe_inst", exe_inst, held_inst);
        end
        held_valid = exe_valid && !exe_ready;
        held_pc = exe_pc;
        held_inst = exe_inst;
        if (exe_valid && exe_ready) follow_issue();
        if (imem_req_valid && rsp_busy) begin
            stop_with_failure("imem request raised while the previous one is outstanding");
        end
        serve_memory();
        exe_ready <= bp_random ? rand_bit() : 1'b1;
    end
end

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        stop_with_failure("timeout, the DUT stopped issuing instructions");
    end
end

// program is loaded while reset is held for 5 cycles
task automatic restart_with_program(input logic lat, input logic bp,
                                    input int branch_every, input int jump_every);
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    lat_random = lat;
    bp_random = bp;
    build_program(branch_every, jump_every);
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_flag("imem_req_valid", imem_req_valid, 1'b0);
    check_flag("exe_valid", exe_valid, 1'b0);
    check_state("state", state, RST);
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    // first cycle out of reset is still quiet
    check_state("state", state, RST);
    check_flag("imem_req_valid", imem_req_valid, 1'b0);
    check_flag("imem_rsp_ready", imem_rsp_ready, 1'b0);
    check_flag("exe_valid", exe_valid, 1'b0);
endtask

task automatic wait_issued(input int n);
    while (issued < n) @(negedge clk);
endtask

task automatic test_reset();
    restart_with_program(1'b0, 1'b0, 0, 0);
    wait_issued(N_RESET);
endtask

task automatic test_straight_line();
    restart_with_program(1'b0, 1'b0, 0, 0);
    wait_issued(N_STRAIGHT);
endtask

task automatic test_random_latency();
    restart_with_program(1'b1, 1'b0, 0, 0);
    wait_issued(N_LATENCY);
endtask

task automatic test_jal();
    restart_with_program(1'b0, 1'b0, 0, 4);
    wait_issued(N_JAL);
endtask

task automatic test_branches();
    restart_with_program(1'b0, 1'b0, 3, 0);
    wait_issued(N_BRANCH);
endtask

task automatic test_backpressure();
    restart_with_program(1'b1, 1'b1, 3, 5);
    wait_issued(N_BACKPRESSURE);
endtask

initial begin
    rst = 1'b1;
    lat_random = 1'b0;
    bp_random = 1'b0;
    test_reset();
    test_straight_line();
    test_random_latency();
    test_jal();
    test_branches();
    test_backpressure();
    $display("TESTS PASSED");
    $finish;
end

endmodule

// ==== sources.f ====
+incdir+include
verilog/rv_fe_pkg.sv
verilog/rv_fe_pc_gen.sv
verilog/rv_fe_decode.sv
verilog/rv_fe_exec.sv
verilog/rv_fe_ctrl.sv
verilog/rv_fe_top.sv
sim/rv_fe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module rv_fe_tb -o rv_fe_sim &&
./obj_dir/rv_fe_sim || exit 1
